// ==== ooo_consts.svh ====
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// tag and datapath widths
`define ROB_TAG_LEN 5
`define DATA_LEN 32

// entries per ready queue
`define QUEUE_DEPTH 4

// class latencies in cycles, issue to writeback
`define LAT_INT 1
`define LAT_BR 1
`define LAT_MEM 4
`define LAT_MUL 8

// scoreboard depth, must cover the longest latency
`define MAX_LAT 8

`endif

// ==== ooo_pkg.sv ====
`default_nettype none
`include "ooo_consts.svh"

package ooo_pkg;

    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;
    typedef logic [`DATA_LEN-1:0] data_t;

    // index of queue, issue bit and pipeline
    typedef enum logic [1:0] {
        FU_INT = 2'd0,
        FU_BR  = 2'd1,
        FU_MEM = 2'd2,
        FU_MUL = 2'd3
    } fu_class_t;

    typedef struct packed {
        rob_tag_t tag;
        data_t    a;
        data_t    b;
    } instr_t;

    typedef struct packed {
        rob_tag_t tag;
        data_t    value;
    } result_t;

endpackage

`default_nettype wire

// ==== ready_queue.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ooo_consts.svh"

module ready_queue import ooo_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  instr_t push_instr,
    input  logic   pop,
    output instr_t head,
    output logic   not_empty,
    output logic   full
);

    localparam int PTR_W = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    instr_t           mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(`QUEUE_DEPTH));
    assign head      = mem[rd_ptr];

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    // dispatch side must watch the full level
    a_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !full)
        else $error("ready_queue: push while full");

    // issue side only pops a class it saw ready
    a_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> not_empty)
        else $error("ready_queue: pop while empty");

endmodule

`default_nettype wire

// ==== issue_unit.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ooo_consts.svh"

module issue_unit import ooo_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] instr_ready,
    output logic [3:0] issue_signal
);

    localparam int CNT_W = $clog2(`MAX_LAT + 1);
    localparam int CLASS_LAT [4] = '{`LAT_INT, `LAT_BR, `LAT_MEM, `LAT_MUL};

    // bit k set means a result lands k cycles from now
    logic [`MAX_LAT-1:0]     slots;
    logic [`MAX_LAT-1:0]     new_slot;
    logic [2:0][CNT_W-1:0]   busy_cnt;  // int, br, mem
    logic [3:0]              unit_free;
    logic [3:0]              slot_taken;
    logic [3:0]              qualify;

    for (genvar c = 0; c < 4; c++) begin : g_class
        if (c == int'(FU_MUL)) begin : g_pipelined
            assign unit_free[c] = 1'b1;  // multiplier takes one per cycle
        end else begin : g_counted
            assign unit_free[c] = (busy_cnt[c] == '0);
        end

        // nothing is reserved a full depth ahead
        if (CLASS_LAT[c] < `MAX_LAT) begin : g_slot
            assign slot_taken[c] = slots[CLASS_LAT[c]];
        end else begin : g_no_slot
            assign slot_taken[c] = 1'b0;
        end

        assign qualify[c] = instr_ready[c] && unit_free[c] && !slot_taken[c];
    end

    // lowest qualifying class wins
    assign issue_signal = qualify & (~qualify + 4'd1);

    // slot the issued result will hold after the next shift
    always_comb begin
        new_slot = '0;
        for (int c = 0; c < 4; c++) begin
            if (issue_signal[c]) begin
                new_slot[CLASS_LAT[c] - 1] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slots    <= '0;
            busy_cnt <= '0;
        end else begin
            slots <= {1'b0, slots[`MAX_LAT-1:1]} | new_slot;
            for (int c = 0; c < 3; c++) begin
                if (issue_signal[c]) begin
                    busy_cnt[c] <= CNT_W'(CLASS_LAT[c] - 1);  // free again on its wb cycle
                end else if (busy_cnt[c] != '0) begin
                    busy_cnt[c] <= busy_cnt[c] - 1'b1;
                end
            end
        end
    end

    // a shorter class issued later must not finish on a held slot
    for (genvar lo = 0; lo < 4; lo++) begin : g_late
        for (genvar sh = 0; sh < 4; sh++) begin : g_short
            if (CLASS_LAT[lo] > CLASS_LAT[sh]) begin : g_gap
                a_slot_free: assert property (@(posedge clk) disable iff (reset)
                    issue_signal[lo] |-> ##(CLASS_LAT[lo] - CLASS_LAT[sh])
                        !issue_signal[sh])
                    else $error("issue_unit: issue into a reserved slot");
            end
        end
    end

    // load/store unit holds one address at a time
    a_mem_single: assert property (@(posedge clk) disable iff (reset)
        issue_signal[FU_MEM] |=> (!issue_signal[FU_MEM]) [*(`LAT_MEM - 1)])
        else $error("issue_unit: memory unit issued while busy");

endmodule

`default_nettype wire

// ==== fu_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_pipe import ooo_pkg::*; #(
    parameter int        LATENCY = 1,
    parameter fu_class_t FU_KIND = FU_INT
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    out_valid,
    output result_t out_result
);

    result_t              entry_res;
    logic [LATENCY-1:0]   valid_q;
    result_t              res_q [LATENCY];

    // result is formed on entry, the stages only delay it
    always_comb begin
        entry_res.tag = in_instr.tag;
        case (FU_KIND)
            FU_INT:  entry_res.value = in_instr.a + in_instr.b;
            FU_BR:   entry_res.value = (in_instr.a == in_instr.b) ? data_t'(1) : '0;
            FU_MEM:  entry_res.value = in_instr.a + in_instr.b;  // effective address
            default: entry_res.value = in_instr.a * in_instr.b;  // low half of product
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q << 1) | LATENCY'(in_valid);
        end
    end

    always_ff @(posedge clk) begin
        res_q[0] <= entry_res;
        for (int s = 1; s < LATENCY; s++) begin
            res_q[s] <= res_q[s-1];
        end
    end

    assign out_valid  = valid_q[LATENCY-1];
    assign out_result = res_q[LATENCY-1];

endmodule

`default_nettype wire

// ==== result_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_bus import ooo_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic [3:0]    fu_valid,
    input  result_t [3:0] fu_result,
    output logic          wb_valid,
    output result_t       wb_result
);

    assign wb_valid = |fu_valid;

    // and-or mux, idle units contribute zero
    always_comb begin
        wb_result = '0;
        for (int u = 0; u < 4; u++) begin
            if (fu_valid[u]) begin
                wb_result = result_t'(wb_result | fu_result[u]);
            end
        end
    end

    // only holds if issue kept every completion slot unique
    a_single_writer: assert property (@(posedge clk) disable iff (reset)
        $onehot0(fu_valid))
        else $error("result_bus: two units wrote back in one cycle");

endmodule

`default_nettype wire

// ==== ooo_backend.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ooo_consts.svh"

module ooo_backend import ooo_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  fu_class_t dispatch_class,
    input  instr_t    dispatch_instr,
    output logic [3:0] queue_full,
    output logic      wb_valid,
    output result_t   wb_result
);

    localparam int FU_LAT [4] = '{`LAT_INT, `LAT_BR, `LAT_MEM, `LAT_MUL};

    logic [3:0]    instr_ready;
    logic [3:0]    issue_signal;
    instr_t [3:0]  queue_head;
    logic [3:0]    fu_valid;
    result_t [3:0] fu_result;

    for (genvar c = 0; c < 4; c++) begin : g_class
        ready_queue ready_queue_inst (
            .clk        (clk),
            .reset      (reset),
            .push       (dispatch_valid && (dispatch_class == fu_class_t'(c))),
            .push_instr (dispatch_instr),
            .pop        (issue_signal[c]),
            .head       (queue_head[c]),
            .not_empty  (instr_ready[c]),
            .full       (queue_full[c])
        );

        // issue pulse pops the head straight into the unit
        fu_pipe #(
            .LATENCY (FU_LAT[c]),
            .FU_KIND (fu_class_t'(c))
        ) fu_pipe_inst (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (issue_signal[c]),
            .in_instr   (queue_head[c]),
            .out_valid  (fu_valid[c]),
            .out_result (fu_result[c])
        );
    end

    issue_unit issue_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .instr_ready  (instr_ready),
        .issue_signal (issue_signal)
    );

    result_bus result_bus_inst (
        .clk       (clk),
        .reset     (reset),
        .fu_valid  (fu_valid),
        .fu_result (fu_result),
        .wb_valid  (wb_valid),
        .wb_result (wb_result)
    );

endmodule

`default_nettype wire

// ==== tb_ooo_backend.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ooo_consts.svh"

module tb_ooo_backend import ooo_pkg::*; ();

    localparam int N_TAGS    = 1 << `ROB_TAG_LEN;
    localparam int WORDS     = 5;  // class, tag, a, b, expected
    localparam int BURST_LEN = 8;

    logic       clk;
    logic       reset;
    logic       dispatch_valid;
    fu_class_t  dispatch_class;
    instr_t     dispatch_instr;
    logic [3:0] queue_full;
    logic       wb_valid;
    result_t    wb_result;

    logic [31:0] vec_mem [N_TAGS*WORDS];
    data_t       exp_value [N_TAGS];
    fu_class_t   exp_class [N_TAGS];
    logic        sent [N_TAGS];
    logic        in_burst [N_TAGS];
    int          seq_no [N_TAGS];
    int          got_cnt [N_TAGS];
    int          sent_cnt [4];
    int          done_cnt [4];
    logic [3:0]  saw_full;
    int          n_sent;
    int          n_got;
    int          n_total;
    int          checks;
    int          errors;
    logic        loaded;
    integer      seed;

    ooo_backend ooo_backend_inst (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_class (dispatch_class),
        .dispatch_instr (dispatch_instr),
        .queue_full     (queue_full),
        .wb_valid       (wb_valid),
        .wb_result      (wb_result)
    );

    always #5 clk = ~clk;

    function automatic string test_name(input rob_tag_t tag);
        if (in_burst[tag]) begin
            return "mul_burst";
        end
        case (exp_class[tag])
            FU_INT:  return "int_add";
            FU_BR:   return "br_eq";
            FU_MEM:  return "mem_addr";
            default: return "mul";
        endcase
    endfunction

    task automatic print_counts();
        $display("checks: %0d  errors: %0d  writebacks: %0d of %0d",
                 checks, errors, n_got, n_sent);
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic send(input fu_class_t cls, input rob_tag_t tag, input data_t a,
                        input data_t b, input data_t expected);
        while (queue_full[cls]) begin
            saw_full[cls] = 1'b1;
            @(posedge clk);
            #1;
        end
        if (sent[tag]) begin
            errors++;
            $display("tag %0d is dispatched a second time by the stimulus", tag);
        end
        sent[tag]      = 1'b1;
        exp_value[tag] = expected;
        exp_class[tag] = cls;
        seq_no[tag]    = sent_cnt[cls];
        sent_cnt[cls]++;
        n_sent++;
        dispatch_valid      = 1'b1;
        dispatch_class      = cls;
        dispatch_instr.tag  = tag;
        dispatch_instr.a    = a;
        dispatch_instr.b    = b;
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic check_wb(input result_t r);
        rob_tag_t  tag;
        fu_class_t cls;
        tag = r.tag;
        if (!sent[tag]) begin
            errors++;
            $display("writeback for tag %0d, which was never dispatched", tag);
            return;
        end
        cls = exp_class[tag];
        got_cnt[tag]++;
        if (got_cnt[tag] > 1) begin
            errors++;
            $display("tag %0d was written back more than once", tag);
            return;
        end
        n_got++;
        checks++;
        if (r.value != exp_value[tag]) begin
            errors++;
            $display("[FAIL] %s tag %0d: expected %h, actual %h",
                     test_name(tag), tag, exp_value[tag], r.value);
        end
        if (seq_no[tag] != done_cnt[cls]) begin
            errors++;
            $display("%s tag %0d completed out of dispatch order", test_name(tag), tag);
        end
        done_cnt[cls]++;
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            check_wb(wb_result);
        end
    end

    initial begin
        wait (loaded);
        repeat (n_total * (`MAX_LAT + `QUEUE_DEPTH) + 50) @(posedge clk);
        errors++;
        $display("timeout: the watchdog limit passed with writebacks still missing");
        print_counts();
        $display("Errors found");
        $finish;
    end

    initial begin
        int                     n_file;
        data_t                  a;
        data_t                  b;
        logic [2*`DATA_LEN-1:0] prod;
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_class = FU_INT;
        dispatch_instr = '0;
        loaded   = 1'b0;
        saw_full = '0;
        n_sent   = 0;
        n_got    = 0;
        checks   = 0;
        errors   = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            sent[t]      = 1'b0;
            in_burst[t]  = 1'b0;
            got_cnt[t]   = 0;
            seq_no[t]    = 0;
            exp_value[t] = '0;
            exp_class[t] = FU_INT;
        end
        for (int c = 0; c < 4; c++) begin
            sent_cnt[c] = 0;
            done_cnt[c] = 0;
        end
        for (int i = 0; i < N_TAGS * WORDS; i++) begin
            vec_mem[i] = {16'hdead, 16'(i)};  // no valid class word
        end
        $readmemh("ooo_input.txt", vec_mem);
        n_file = 0;
        while (n_file < N_TAGS && vec_mem[n_file*WORDS] <= 32'd3) begin
            n_file++;
        end
        n_total = n_file + BURST_LEN;
        loaded  = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // idle backend before any dispatch
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (wb_valid || queue_full != 4'b0000) begin
                errors++;
                $display("[FAIL] reset_idle: expected wb_valid 0 queue_full 0000, actual %b %b",
                         wb_valid, queue_full);
            end
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < n_file; i++) begin
            send(fu_class_t'(vec_mem[i*WORDS][1:0]), vec_mem[i*WORDS+1][`ROB_TAG_LEN-1:0],
                 vec_mem[i*WORDS+2], vec_mem[i*WORDS+3], vec_mem[i*WORDS+4]);
        end

        // back-to-back multiplies on the top tags
        seed = 32'h2ead;
        for (int k = 0; k < BURST_LEN; k++) begin
            a = $random(seed);
            b = $random(seed);
            prod = {{`DATA_LEN{1'b0}}, a} * {{`DATA_LEN{1'b0}}, b};  // low word of the full product
            in_burst[N_TAGS - BURST_LEN + k] = 1'b1;
            send(FU_MUL, rob_tag_t'(N_TAGS - BURST_LEN + k), a, b, prod[`DATA_LEN-1:0]);
        end

        wait (n_got == n_sent);
        repeat (`MAX_LAT + 2) @(posedge clk);  // room for a late duplicate

        if (saw_full == 4'b0000) begin
            errors++;
            $display("no ready queue ever reported full during the stream");
        end
        print_counts();
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ooo_input.txt ====
// columns: class tag a b expected, all hex
// class 0 int add, 1 branch equal, 2 load/store address, 3 multiply
// integer
0 00 00000005 00000007 0000000c
0 01 ffffffff 00000001 00000000
0 02 12345678 11111111 23456789
0 03 80000000 80000000 00000000
// branch
1 04 0000002a 0000002a 00000001
1 05 0000002a 0000002b 00000000
1 06 deadbeef deadbeef 00000001
1 07 00000000 80000000 00000000
// load/store back to back, fills its queue
2 08 00001000 00000010 00001010
2 09 00001000 00000020 00001020
2 0a 00002000 00000004 00002004
2 0b 00002000 fffffffc 00001ffc
2 0c 00004000 00000100 00004100
2 0d 0000fff0 00000010 00010000
2 0e 7ffffff0 00000020 80000010
// multiply
3 0f 00000003 00000007 00000015
3 10 00010000 00010000 00000000
3 11 ffffffff 00000002 fffffffe
3 12 00001234 00000010 00012340
// mixed classes
0 13 00000064 00000036 0000009a
3 14 0000000b 0000000d 0000008f
1 15 00000001 00000002 00000000
2 16 00000100 00000200 00000300
0 17 00000010 fffffff0 00000000

// ==== sim.f ====
+incdir+.
ooo_pkg.sv
ready_queue.sv
issue_unit.sv
fu_pipe.sv
result_bus.sv
ooo_backend.sv
tb_ooo_backend.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_backend -f sim.f
	./obj_dir/Vtb_ooo_backend | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
